// File: hw/csr_pkg.sv
// csr package
// shared widths, CSR addresses, field positions and the structs that
// travel between the access decoder, trap state and counter blocks
package csr_pkg;

  ////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////
  localparam int XLEN_W     = 32;
  localparam int CSR_ADDR_W = 12;
  // top bit flags an interrupt
  localparam int CAUSE_W    = 6;
  localparam int N_PERF_CNT = 11;
  localparam int PERF_IDX_W = 4;

  // machine-mode CSR map
  localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS   = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC     = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC      = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE    = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID   = 12'hF14;
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCER      = 12'h7A0;
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCMR      = 12'h7A1;
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCCR_BASE = 12'h780;

  // field positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;
  localparam int MCAUSE_IRQ_BIT   = 31;
  // 24-bit trap base sits above these zero bits
  localparam int MTVEC_LSB        = 8;

  // counting on, saturation on
  localparam logic [1:0] PCMR_RESET = 2'b11;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // decoded write request, selects are one-hot
  typedef struct packed {
    logic                  we;
    logic [XLEN_W-1:0]     wdata;
    logic                  sel_mstatus;
    logic                  sel_mepc;
    logic                  sel_mcause;
    logic                  sel_pcer;
    logic                  sel_pcmr;
    logic                  sel_pccr;
    logic [PERF_IDX_W-1:0] pccr_idx;
  } csr_wr_t;

  // raw core events, sampled every cycle
  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic is_compressed;
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic jr_stall;
    logic mem_load;
    logic mem_store;
  } perf_events_t;

  // trap entry and return controls from the core controller
  typedef struct packed {
    logic               save_cause;
    logic               save_if;
    logic               save_id;
    logic               restore_mret;
    logic [CAUSE_W-1:0] cause;
    logic [XLEN_W-1:0]  pc_if;
    logic [XLEN_W-1:0]  pc_id;
  } trap_ctrl_t;

endpackage

// File: hw/csr_access_decode.sv
// csr access decoder
// turns the core access into one-hot selects, merges read data and
// computes the effective write data for write, set and clear
`timescale 1ns/10ps

module csr_access_decode (
  input  logic                                csr_access_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]      csr_addr_i,
  input  csr_pkg::csr_op_e                    csr_op_i,
  input  logic [csr_pkg::XLEN_W-1:0]          csr_wdata_i,
  input  logic [csr_pkg::XLEN_W-1:0]          trap_rdata_i,
  input  logic [csr_pkg::XLEN_W-1:0]          perf_rdata_i,
  output logic [csr_pkg::XLEN_W-1:0]          csr_rdata_o,
  output csr_pkg::csr_wr_t                    wr_o
);
  import csr_pkg::*;

  logic pccr_hit;

  // counter window 0x780..0x78A, upper part of 0x78x is unmapped
  assign pccr_hit = (csr_addr_i[CSR_ADDR_W-1:PERF_IDX_W] ==
                     ADDR_PCCR_BASE[CSR_ADDR_W-1:PERF_IDX_W]) &&
                    (csr_addr_i[PERF_IDX_W-1:0] < PERF_IDX_W'(N_PERF_CNT));

  // blocks return zero when not selected, so a plain OR merges them
  assign csr_rdata_o = trap_rdata_i | perf_rdata_i;

  always_comb begin
    wr_o = '0;

    // selects only while the core actually accesses
    wr_o.sel_mstatus = csr_access_i && (csr_addr_i == ADDR_MSTATUS);
    wr_o.sel_mepc    = csr_access_i && (csr_addr_i == ADDR_MEPC);
    wr_o.sel_mcause  = csr_access_i && (csr_addr_i == ADDR_MCAUSE);
    wr_o.sel_pcer    = csr_access_i && (csr_addr_i == ADDR_PCER);
    wr_o.sel_pcmr    = csr_access_i && (csr_addr_i == ADDR_PCMR);
    wr_o.sel_pccr    = csr_access_i && pccr_hit;
    wr_o.pccr_idx    = csr_addr_i[PERF_IDX_W-1:0];

    wr_o.we = (csr_op_i != CSR_OP_NONE);

    // read-modify-write against the current read value
    case (csr_op_i)
      CSR_OP_WRITE: wr_o.wdata = csr_wdata_i;
      CSR_OP_SET:   wr_o.wdata = csr_rdata_o | csr_wdata_i;
      CSR_OP_CLEAR: wr_o.wdata = csr_rdata_o & ~csr_wdata_i;
      default:      wr_o.wdata = csr_wdata_i;
    endcase
  end

endmodule

// File: hw/trap_status_regs.sv
// trap and status registers
// mstatus, mepc, mcause with trap entry and mret, plus read-only
// mtvec and mhartid read data
`timescale 1ns/10ps

module trap_status_regs (
  input  logic                                clk,
  input  logic                                rst_n,
  input  csr_pkg::csr_wr_t                    wr_i,
  input  csr_pkg::trap_ctrl_t                 trap_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]      csr_addr_i,
  input  logic [3:0]                          core_id_i,
  input  logic [5:0]                          cluster_id_i,
  input  logic [23:0]                         boot_addr_i,
  output logic [csr_pkg::XLEN_W-1:0]          trap_rdata_o,
  output logic [csr_pkg::XLEN_W-1:0]          epc_o,
  output logic [23:0]                         mtvec_o,
  output logic                                irq_enable_o
);
  import csr_pkg::*;

  logic               mie_q, mie_d;
  logic               mpie_q, mpie_d;
  logic [XLEN_W-1:0]  mepc_q, mepc_d;
  logic [CAUSE_W-1:0] mcause_q, mcause_d;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////
  always_comb begin
    mie_d    = mie_q;
    mpie_d   = mpie_q;
    mepc_d   = mepc_q;
    mcause_d = mcause_q;

    // plain csr writes first
    if (wr_i.we) begin
      // mpp is fixed at machine, only the enable bits are writable
      if (wr_i.sel_mstatus) begin
        mie_d  = wr_i.wdata[MSTATUS_MIE_BIT];
        mpie_d = wr_i.wdata[MSTATUS_MPIE_BIT];
      end
      if (wr_i.sel_mepc) begin
        mepc_d = wr_i.wdata;
      end
      // irq flag plus low cause code
      if (wr_i.sel_mcause) begin
        mcause_d = {wr_i.wdata[MCAUSE_IRQ_BIT], wr_i.wdata[CAUSE_W-2:0]};
      end
    end

    // controller events override the csr write
    if (trap_i.save_cause) begin
      mepc_d   = trap_i.save_if ? trap_i.pc_if : trap_i.pc_id;
      mcause_d = trap_i.cause;
      mpie_d   = mie_q;
      mie_d    = 1'b0;
    end else if (trap_i.restore_mret) begin
      mie_d  = mpie_q;
      mpie_d = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_d;
      mpie_q   <= mpie_d;
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////
  always_comb begin
    trap_rdata_o = '0;
    if (wr_i.sel_mstatus) begin
      trap_rdata_o[MSTATUS_MIE_BIT]                       = mie_q;
      trap_rdata_o[MSTATUS_MPIE_BIT]                      = mpie_q;
      trap_rdata_o[MSTATUS_MPP_LSB+1:MSTATUS_MPP_LSB]     = 2'b11;
    end else if (wr_i.sel_mepc) begin
      trap_rdata_o = mepc_q;
    end else if (wr_i.sel_mcause) begin
      trap_rdata_o[MCAUSE_IRQ_BIT] = mcause_q[CAUSE_W-1];
      trap_rdata_o[CAUSE_W-2:0]    = mcause_q[CAUSE_W-2:0];
    end else if (csr_addr_i == ADDR_MTVEC) begin
      // read-only, decoded straight from the address
      trap_rdata_o = {boot_addr_i, {MTVEC_LSB{1'b0}}};
    end else if (csr_addr_i == ADDR_MHARTID) begin
      trap_rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
    end
  end

  // direct outputs to the core
  assign epc_o        = mepc_q;
  assign mtvec_o      = boot_addr_i;
  assign irq_enable_o = mie_q;

endmodule

// File: hw/perf_event_sample.sv
// performance event sampler
// first counter stage, forms the raw event vector, masks it with pcer
// and the global enable and registers the increment requests
`timescale 1ns/10ps

module perf_event_sample (
  input  logic                                clk,
  input  logic                                rst_n,
  input  csr_pkg::perf_events_t               events_i,
  input  logic [csr_pkg::N_PERF_CNT-1:0]      pcer_i,
  input  logic                                count_en_i,
  output logic [csr_pkg::N_PERF_CNT-1:0]      inc_o
);
  import csr_pkg::*;

  logic                  id_valid_q;
  logic [N_PERF_CNT-1:0] raw_ev;
  logic [N_PERF_CNT-1:0] inc_d;
  logic [N_PERF_CNT-1:0] inc_q;

  // event map, index is the counter number
  assign raw_ev[0]  = 1'b1;
  assign raw_ev[1]  = events_i.id_valid & events_i.is_decoding;
  // stalls are only counted once id has moved on
  assign raw_ev[2]  = events_i.ld_stall & id_valid_q;
  assign raw_ev[3]  = events_i.jr_stall & id_valid_q;
  // fetch wait, jumps and branches excluded
  assign raw_ev[4]  = events_i.imiss & ~events_i.pc_set;
  assign raw_ev[5]  = events_i.mem_load;
  assign raw_ev[6]  = events_i.mem_store;
  assign raw_ev[7]  = events_i.jump & id_valid_q;
  assign raw_ev[8]  = events_i.branch & id_valid_q;
  assign raw_ev[9]  = events_i.branch & events_i.branch_taken & id_valid_q;
  assign raw_ev[10] = events_i.id_valid & events_i.is_decoding & events_i.is_compressed;

  // per-counter enable and global enable
  assign inc_d = raw_ev & pcer_i & {N_PERF_CNT{count_en_i}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
    end else begin
      id_valid_q <= events_i.id_valid;
      inc_q      <= inc_d;
    end
  end

  assign inc_o = inc_q;

endmodule

// File: hw/perf_counter_bank.sv
// performance counter bank
// second counter stage, holds the 32-bit counters with pcer and pcmr,
// handles saturation and csr writes and returns counter read data
`timescale 1ns/10ps

module perf_counter_bank (
  input  logic                                clk,
  input  logic                                rst_n,
  input  csr_pkg::csr_wr_t                    wr_i,
  input  logic [csr_pkg::N_PERF_CNT-1:0]      inc_i,
  output logic [csr_pkg::XLEN_W-1:0]          perf_rdata_o,
  output logic [csr_pkg::N_PERF_CNT-1:0]      pcer_o,
  output logic                                count_en_o
);
  import csr_pkg::*;

  logic [N_PERF_CNT-1:0][XLEN_W-1:0] cnt_q;
  logic [N_PERF_CNT-1:0]             pcer_q;
  // bit 0 global enable, bit 1 saturate
  logic [1:0]                        pcmr_q;

  ////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < N_PERF_CNT; i++) begin
        // hold at all ones when saturating
        if (inc_i[i] && !(pcmr_q[1] && (cnt_q[i] == '1))) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
        // software write wins over an increment
        if (wr_i.we && wr_i.sel_pccr && (wr_i.pccr_idx == PERF_IDX_W'(i))) begin
          cnt_q[i] <= wr_i.wdata;
        end
      end
    end
  end

  // mode and event-enable registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      pcmr_q <= PCMR_RESET;
    end else begin
      if (wr_i.we && wr_i.sel_pcer) begin
        pcer_q <= wr_i.wdata[N_PERF_CNT-1:0];
      end
      if (wr_i.we && wr_i.sel_pcmr) begin
        pcmr_q <= wr_i.wdata[1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read data, zero when nothing here is selected
  ////////////////////////////////////////////////////////////
  always_comb begin
    perf_rdata_o = '0;
    if (wr_i.sel_pcer) begin
      perf_rdata_o[N_PERF_CNT-1:0] = pcer_q;
    end else if (wr_i.sel_pcmr) begin
      perf_rdata_o[1:0] = pcmr_q;
    end else if (wr_i.sel_pccr) begin
      // index mux over the valid counters only
      for (int i = 0; i < N_PERF_CNT; i++) begin
        if (wr_i.pccr_idx == PERF_IDX_W'(i)) begin
          perf_rdata_o = cnt_q[i];
        end
      end
    end
  end

  // feed the masks back to the sampling stage
  assign pcer_o     = pcer_q;
  assign count_en_o = pcmr_q[0];

endmodule

// File: hw/csr_unit_top.sv
// machine-mode csr unit
// single-cycle csr port, trap state and the two-stage counter path
`timescale 1ns/10ps

module csr_unit_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                csr_access_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]      csr_addr_i,
  input  csr_pkg::csr_op_e                    csr_op_i,
  input  logic [csr_pkg::XLEN_W-1:0]          csr_wdata_i,
  output logic [csr_pkg::XLEN_W-1:0]          csr_rdata_o,
  input  logic [3:0]                          core_id_i,
  input  logic [5:0]                          cluster_id_i,
  input  logic [23:0]                         boot_addr_i,
  input  csr_pkg::trap_ctrl_t                 trap_i,
  input  csr_pkg::perf_events_t               events_i,
  output logic [csr_pkg::XLEN_W-1:0]          epc_o,
  output logic [23:0]                         mtvec_o,
  output logic                                irq_enable_o
);

  csr_pkg::csr_wr_t                    wr;
  logic [csr_pkg::XLEN_W-1:0]          trap_rdata;
  logic [csr_pkg::XLEN_W-1:0]          perf_rdata;
  logic [csr_pkg::N_PERF_CNT-1:0]      pcer;
  logic                                count_en;
  logic [csr_pkg::N_PERF_CNT-1:0]      inc;

  // access decode and read merge
  csr_access_decode u_decode (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .trap_rdata_i (trap_rdata),
    .perf_rdata_i (perf_rdata),
    .csr_rdata_o  (csr_rdata_o),
    .wr_o         (wr)
  );

  trap_status_regs u_trap (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_i         (wr),
    .trap_i       (trap_i),
    .csr_addr_i   (csr_addr_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .boot_addr_i  (boot_addr_i),
    .trap_rdata_o (trap_rdata),
    .epc_o        (epc_o),
    .mtvec_o      (mtvec_o),
    .irq_enable_o (irq_enable_o)
  );

  // counter stage one
  perf_event_sample u_sample (
    .clk        (clk),
    .rst_n      (rst_n),
    .events_i   (events_i),
    .pcer_i     (pcer),
    .count_en_i (count_en),
    .inc_o      (inc)
  );

  // counter stage two
  perf_counter_bank u_bank (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_i         (wr),
    .inc_i        (inc),
    .perf_rdata_o (perf_rdata),
    .pcer_o       (pcer),
    .count_en_o   (count_en)
  );

endmodule

// File: verification/tb_clk_gen.sv
// testbench clock and reset
// 8 ns clock, reset held low for the first 3 cycles
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    // release away from the sampling edge
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

  always #4 clk_o = ~clk_o;

endmodule

// File: verification/csr_unit_tb.sv
// csr unit testbench
// random csr traffic, traps and event streams checked against a
// reference model kept in the testbench
`timescale 1ns/10ps

module csr_unit_tb;
  import csr_pkg::*;

  // tests take about 1100 cycles, watchdog leaves a wide margin
  localparam int WATCHDOG_CYCLES = 20000;
  localparam int CLK_PERIOD_NS   = 8;
  localparam logic [CSR_ADDR_W-1:0] RW_ADDRS [5] =
    '{ADDR_MSTATUS, ADDR_MEPC, ADDR_MCAUSE, ADDR_PCER, ADDR_PCMR};
  localparam logic [CSR_ADDR_W-1:0] TRAP_ADDRS [3] = '{ADDR_MSTATUS, ADDR_MEPC, ADDR_MCAUSE};

  logic                  clk;
  logic                  rst_n;
  logic                  csr_access;
  logic [CSR_ADDR_W-1:0] csr_addr;
  csr_op_e               csr_op;
  logic [XLEN_W-1:0]     csr_wdata;
  logic [XLEN_W-1:0]     csr_rdata;
  logic [3:0]            core_id;
  logic [5:0]            cluster_id;
  logic [23:0]           boot_addr;
  trap_ctrl_t            trap;
  perf_events_t          events;
  logic [XLEN_W-1:0]     epc;
  logic [23:0]           mtvec;
  logic                  irq_enable;

  // reference model, mcause kept in its read form
  logic                  m_mie;
  logic                  m_mpie;
  logic [XLEN_W-1:0]     m_mepc;
  logic [XLEN_W-1:0]     m_mcause;
  logic [N_PERF_CNT-1:0] m_pcer;
  logic [1:0]            m_pcmr;
  logic [XLEN_W-1:0]     m_cnt [N_PERF_CNT];
  // increments waiting for the next edge, id_valid one edge back
  logic [N_PERF_CNT-1:0] m_inc;
  logic                  m_idv_q;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int failed_tests = 0;
  int test_err0 = 0;

  tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

  csr_unit_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_access_i (csr_access),
    .csr_addr_i   (csr_addr),
    .csr_op_i     (csr_op),
    .csr_wdata_i  (csr_wdata),
    .csr_rdata_o  (csr_rdata),
    .core_id_i    (core_id),
    .cluster_id_i (cluster_id),
    .boot_addr_i  (boot_addr),
    .trap_i       (trap),
    .events_i     (events),
    .epc_o        (epc),
    .mtvec_o      (mtvec),
    .irq_enable_o (irq_enable)
  );

  ////////////////////////////////////////////////////////////
  // checking and reporting
  ////////////////////////////////////////////////////////////
  task automatic check_equal(input logic [XLEN_W-1:0] got, input logic [XLEN_W-1:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != test_err0) failed_tests++;
    $display("test %s: %s, %0d errors", name, (errors == test_err0) ? "ok" : "FAILED",
             errors - test_err0);
    test_err0 = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////
  function automatic logic [XLEN_W-1:0] model_read(input logic [CSR_ADDR_W-1:0] addr);
    logic [XLEN_W-1:0] val;
    val = '0;
    case (addr)
      // mpp always reads as machine
      ADDR_MSTATUS: val = 32'h0000_1800 | (32'(m_mpie) << 7) | (32'(m_mie) << 3);
      ADDR_MEPC:    val = m_mepc;
      ADDR_MCAUSE:  val = m_mcause;
      ADDR_MTVEC:   val = 32'(boot_addr) << 8;
      // cluster id at 10:5, core id at 3:0
      ADDR_MHARTID: val = (32'(cluster_id) << 5) | 32'(core_id);
      ADDR_PCER:    val = {21'b0, m_pcer};
      ADDR_PCMR:    val = {30'b0, m_pcmr};
      default: begin
        // counters 0x780 to 0x78A
        if (addr[11:4] == 8'h78 && addr[3:0] < 4'd11) val = m_cnt[addr[3:0]];
      end
    endcase
    return val;
  endfunction

  // one rising edge with the inputs of this cycle
  task automatic model_step(input logic acc, input logic [CSR_ADDR_W-1:0] addr,
                            input csr_op_e op, input logic [XLEN_W-1:0] wd);
    logic [XLEN_W-1:0]     eff;
    logic [N_PERF_CNT-1:0] ev;
    logic                  wr;
    logic                  old_mie;
    logic                  old_mpie;

    wr = acc && (op != CSR_OP_NONE);
    case (op)
      CSR_OP_SET:   eff = model_read(addr) | wd;
      CSR_OP_CLEAR: eff = model_read(addr) & ~wd;
      default:      eff = wd;
    endcase

    // stalls, jumps and branches need id_valid at the edge before
    ev[0]  = 1'b1;
    ev[1]  = events.id_valid & events.is_decoding;
    ev[2]  = events.ld_stall & m_idv_q;
    ev[3]  = events.jr_stall & m_idv_q;
    ev[4]  = events.imiss & ~events.pc_set;
    ev[5]  = events.mem_load;
    ev[6]  = events.mem_store;
    ev[7]  = events.jump & m_idv_q;
    ev[8]  = events.branch & m_idv_q;
    ev[9]  = events.branch & events.branch_taken & m_idv_q;
    ev[10] = events.id_valid & events.is_decoding & events.is_compressed;
    ev     = ev & m_pcer & {N_PERF_CNT{m_pcmr[0]}};

    // last edge's increments land now, a csr write wins
    for (int i = 0; i < N_PERF_CNT; i++) begin
      if (m_inc[i] && !(m_pcmr[1] && m_cnt[i] == '1)) m_cnt[i] = m_cnt[i] + 1;
      if (wr && addr == ADDR_PCCR_BASE + 12'(i)) m_cnt[i] = eff;
    end
    if (wr && addr == ADDR_PCER) m_pcer = eff[N_PERF_CNT-1:0];
    if (wr && addr == ADDR_PCMR) m_pcmr = eff[1:0];
    m_inc   = ev;
    m_idv_q = events.id_valid;

    // trap entry and mret override a same-cycle write
    old_mie  = m_mie;
    old_mpie = m_mpie;
    if (wr && addr == ADDR_MSTATUS) begin
      m_mie  = eff[3];
      m_mpie = eff[7];
    end
    if (wr && addr == ADDR_MEPC) m_mepc = eff;
    if (wr && addr == ADDR_MCAUSE) m_mcause = eff & 32'h8000_001F;
    if (trap.save_cause) begin
      m_mepc   = trap.save_if ? trap.pc_if : trap.pc_id;
      m_mcause = {trap.cause[5], 26'b0, trap.cause[4:0]};
      m_mpie   = old_mie;
      m_mie    = 1'b0;
    end else if (trap.restore_mret) begin
      m_mie  = old_mpie;
      m_mpie = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  // drive on the falling edge, check in the low phase, then step the model
  task automatic run_cycle(input logic acc, input logic [CSR_ADDR_W-1:0] addr,
                           input csr_op_e op, input logic [XLEN_W-1:0] wd,
                           input trap_ctrl_t tr, input perf_events_t ev,
                           output logic [XLEN_W-1:0] rd);
    @(negedge clk);
    csr_access = acc;
    csr_addr   = addr;
    csr_op     = op;
    csr_wdata  = wd;
    trap       = tr;
    events     = ev;
    #2;
    rd = csr_rdata;
    if (acc) check_equal(csr_rdata, model_read(addr), $sformatf("read of csr %h", addr));
    check_equal(epc, m_mepc, "epc_o");
    check_equal({31'b0, irq_enable}, {31'b0, m_mie}, "irq_enable_o");
    model_step(acc, addr, op, wd);
  endtask

  task automatic csr_cycle(input logic [CSR_ADDR_W-1:0] addr, input csr_op_e op,
                           input logic [XLEN_W-1:0] wd, output logic [XLEN_W-1:0] rd);
    run_cycle(1'b1, addr, op, wd, '0, '0, rd);
  endtask

  task automatic idle_cycles(input int n);
    logic [XLEN_W-1:0] rd;
    repeat (n) run_cycle(1'b0, '0, CSR_OP_NONE, '0, '0, '0, rd);
  endtask

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial begin : main
    logic [XLEN_W-1:0]     rd;
    logic [CSR_ADDR_W-1:0] addr;
    logic                  acc;
    csr_op_e               op;
    trap_ctrl_t            tr;
    perf_events_t          ev;

    void'($urandom(32'h8833_6c78));
    core_id    = 4'($urandom());
    cluster_id = 6'($urandom());
    boot_addr  = 24'($urandom());
    csr_access = 1'b0;
    csr_addr   = '0;
    csr_op     = CSR_OP_NONE;
    csr_wdata  = '0;
    trap       = '0;
    events     = '0;
    // model reset state
    m_mie    = 1'b0;
    m_mpie   = 1'b0;
    m_mepc   = '0;
    m_mcause = '0;
    m_pcer   = '0;
    m_pcmr   = 2'b11;
    m_inc    = '0;
    m_idv_q  = 1'b0;
    foreach (m_cnt[i]) m_cnt[i] = '0;
    @(posedge rst_n);

    // reset values
    csr_cycle(ADDR_MSTATUS, CSR_OP_NONE, '0, rd);
    check_equal(rd, 32'h0000_1800, "mstatus after reset");
    csr_cycle(ADDR_PCMR, CSR_OP_NONE, '0, rd);
    check_equal(rd, 32'd3, "pcmr after reset");
    csr_cycle(ADDR_PCER, CSR_OP_NONE, '0, rd);
    check_equal(rd, 32'd0, "pcer after reset");
    for (int i = 0; i < N_PERF_CNT; i++) begin
      csr_cycle(ADDR_PCCR_BASE + 12'(i), CSR_OP_NONE, '0, rd);
      check_equal(rd, 32'd0, $sformatf("counter %0d after reset", i));
    end
    csr_cycle(ADDR_MTVEC, CSR_OP_NONE, '0, rd);
    check_equal(rd, 32'(boot_addr) << 8, "mtvec");
    csr_cycle(ADDR_MHARTID, CSR_OP_NONE, '0, rd);
    check_equal(rd, (32'(cluster_id) << 5) | 32'(core_id), "mhartid");
    check_equal({8'b0, mtvec}, {8'b0, boot_addr}, "mtvec_o");
    end_test("reset values");

    // random csr access
    for (int n = 0; n < 300; n++) begin
      addr = RW_ADDRS[3'($urandom_range(0, 4))];
      op   = csr_op_e'(2'($urandom()));
      csr_cycle(addr, op, $urandom(), rd);
    end
    csr_cycle(ADDR_PCER, CSR_OP_WRITE, '0, rd);
    end_test("random csr access");

    // trap entry and mret
    for (int n = 0; n < 100; n++) begin
      tr            = '0;
      tr.save_cause = 1'($urandom());
      // both raised now and then, trap entry wins
      tr.restore_mret = tr.save_cause ? 1'($urandom()) : 1'b1;
      tr.save_if      = 1'($urandom());
      tr.save_id      = ~tr.save_if;
      tr.cause        = 6'($urandom());
      tr.pc_if        = $urandom();
      tr.pc_id        = $urandom();
      acc  = 1'($urandom());
      addr = acc ? TRAP_ADDRS[2'($urandom_range(0, 2))] : '0;
      op   = acc ? csr_op_e'(2'($urandom())) : CSR_OP_NONE;
      run_cycle(acc, addr, op, $urandom(), tr, '0, rd);
      csr_cycle(TRAP_ADDRS[2'($urandom_range(0, 2))], CSR_OP_NONE, '0, rd);
    end
    end_test("trap and mret");

    // event counting
    csr_cycle(ADDR_PCMR, CSR_OP_WRITE, '0, rd);
    for (int i = 0; i < N_PERF_CNT; i++) begin
      csr_cycle(ADDR_PCCR_BASE + 12'(i), CSR_OP_WRITE, $urandom(), rd);
    end
    csr_cycle(ADDR_PCER, CSR_OP_WRITE, 32'(11'($urandom())), rd);
    csr_cycle(ADDR_PCMR, CSR_OP_WRITE, 32'd1, rd);
    for (int n = 0; n < 500; n++) begin
      ev = 12'($urandom());
      run_cycle(1'b0, '0, CSR_OP_NONE, '0, '0, ev, rd);
    end
    csr_cycle(ADDR_PCMR, CSR_OP_WRITE, '0, rd);
    idle_cycles(2);
    for (int i = 0; i < N_PERF_CNT; i++) begin
      csr_cycle(ADDR_PCCR_BASE + 12'(i), CSR_OP_NONE, '0, rd);
    end
    end_test("event counting");

    // saturation, then wrap, on the cycle counter
    csr_cycle(ADDR_PCMR, CSR_OP_WRITE, '0, rd);
    csr_cycle(ADDR_PCER, CSR_OP_WRITE, 32'd1, rd);
    csr_cycle(ADDR_PCCR_BASE, CSR_OP_WRITE, 32'hFFFF_FFFD, rd);
    csr_cycle(ADDR_PCMR, CSR_OP_WRITE, 32'd3, rd);
    idle_cycles(10);
    csr_cycle(ADDR_PCCR_BASE, CSR_OP_NONE, '0, rd);
    check_equal(rd, 32'hFFFF_FFFF, "saturated counter");
    csr_cycle(ADDR_PCMR, CSR_OP_WRITE, '0, rd);
    csr_cycle(ADDR_PCCR_BASE, CSR_OP_WRITE, 32'hFFFF_FFFD, rd);
    csr_cycle(ADDR_PCMR, CSR_OP_WRITE, 32'd1, rd);
    idle_cycles(10);
    csr_cycle(ADDR_PCCR_BASE, CSR_OP_NONE, '0, rd);
    // first count lands two edges after the enable, so 9 of the 10 idle edges add one
    check_equal(rd, 32'hFFFF_FFFD + 32'(10 - 1), "counter wrapped past zero");
    end_test("saturate and wrap");

    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed_tests, checks,
             errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
hw/csr_pkg.sv
hw/csr_access_decode.sv
hw/trap_status_regs.sv
hw/perf_event_sample.sv
hw/perf_counter_bank.sv
hw/csr_unit_top.sv
verification/tb_clk_gen.sv
verification/csr_unit_tb.sv

// File: Makefile
# Verilator flow for the csr unit and its testbench

TB_TOP = csr_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module csr_unit_top
	verilator --lint-only --timing -f vlog.f --top-module $(TB_TOP)

# the run passes only if the log holds the pass line
sim:
	verilator --binary --timing -f vlog.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "^All tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
